// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal --timescale 1ns/100ps
TOP       = response_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir
PASS_MSG  = All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: design/control_pkg.sv
`include "glay_macros.svh"

package control_pkg;

  // ----------------------------------------
  // Distributor FSM
  // ----------------------------------------

  // SETUP holds until the FIFO leaves its reset-busy period
  typedef enum logic [1:0] {
    SETUP = 2'd0,
    IDLE  = 2'd1,
    SEND  = 2'd2
  } dist_state_e;

  // ----------------------------------------
  // Downstream credit counts
  // ----------------------------------------

  // Count never rises above REQ_CREDITS, a requestor only returns what it took
  typedef logic [`CREDIT_WIDTH-1:0] credit_t;

  localparam credit_t CREDIT_INIT = credit_t'(`REQ_CREDITS);

endpackage : control_pkg

// File: design/credit_counter.sv
`timescale 1ns/100ps

module credit_counter (
  input  logic ap_clk,
  input  logic areset_control,
  input  logic grant,
  input  logic consume,
  output logic avail
);
  import control_pkg::*;

  credit_t count;

  // ----------------------------------------
  // Credit bookkeeping
  // ----------------------------------------

  // Grant and consume in the same cycle cancel out
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      count <= CREDIT_INIT;
    end else begin
      case ({grant, consume})
        2'b10: begin
          count <= count + credit_t'(1);
        end
        2'b01: begin
          count <= count - credit_t'(1);
        end
        default: begin
          count <= count;
        end
      endcase
    end
  end

  // Registered count, so avail lags grant or consume by a cycle
  assign avail = (count != '0);

endmodule : credit_counter

// File: design/fifo_read_if.sv
`timescale 1ns/100ps

interface fifo_read_if;
  import memory_pkg::*;

  // Head of the FWFT FIFO
  logic         head_valid;
  resp_packet_t head_packet;

  // Only asserted while head_valid is high
  logic         pop;

  // FIFO side
  modport source (
    output head_valid,
    output head_packet,
    input  pop
  );

  // Distributor side
  modport sink (
    input  head_valid,
    input  head_packet,
    output pop
  );

endinterface : fifo_read_if

// File: design/glay_macros.svh
`ifndef GLAY_MACROS_SVH
`define GLAY_MACROS_SVH

// ----------------------------------------
// Response return path sizing
// ----------------------------------------

// Response destinations
`define NUM_REQUESTORS    4

// FIFO entries, also the upstream credit pool
`define RESP_FIFO_DEPTH   16
`define FIFO_ADDR_WIDTH   4
`define FIFO_COUNT_WIDTH  5

// Downstream credits per requestor at reset
`define REQ_CREDITS       2
`define CREDIT_WIDTH      3

// Response fields
`define TAG_WIDTH         8
`define DATA_WIDTH        32

// Reset-busy period of the FIFO
`define SETUP_CYCLES      4
`define SETUP_COUNT_WIDTH 3

`endif

// File: design/memory_pkg.sv
`include "glay_macros.svh"

package memory_pkg;

  // ----------------------------------------
  // Response kinds
  // ----------------------------------------
  typedef enum logic [1:0] {
    RESP_READ_DATA = 2'd0,
    RESP_WRITE_ACK = 2'd1
  } resp_opcode_e;

  // ----------------------------------------
  // Response packet as it sits in the FIFO
  // ----------------------------------------

  // One-hot or multi-hot destination mask, one bit per requestor
  typedef logic [`NUM_REQUESTORS-1:0] resp_dest_t;

  typedef logic [`TAG_WIDTH-1:0]  resp_tag_t;
  typedef logic [`DATA_WIDTH-1:0] resp_data_t;

  typedef struct packed {
    resp_opcode_e opcode;
    resp_dest_t   dest;
    resp_tag_t    tag;
    resp_data_t   data;
  } resp_packet_t;

  // Total packet width, handy for storage sizing
  localparam int RESP_PACKET_BITS = $bits(resp_packet_t);

endpackage : memory_pkg

// File: design/response_distributor.sv
`timescale 1ns/100ps
`include "glay_macros.svh"

module response_distributor (
  input  logic                       ap_clk,
  input  logic                       areset_control,
  fifo_read_if.sink                  rd,
  input  logic                       fifo_busy,
  input  logic [`NUM_REQUESTORS-1:0] credit_in,
  output logic [`NUM_REQUESTORS-1:0] out_valid,
  output memory_pkg::resp_opcode_e   out_opcode,
  output logic [`TAG_WIDTH-1:0]      out_tag,
  output logic [`DATA_WIDTH-1:0]     out_data,
  output logic                       mem_credit,
  output logic                       setup_busy
);
  import control_pkg::*;

  dist_state_e state;
  dist_state_e state_next;

  logic [`NUM_REQUESTORS-1:0] dest_mask;
  logic [`NUM_REQUESTORS-1:0] credit_avail;
  logic [`NUM_REQUESTORS-1:0] credit_consume;
  logic                       targets_ready;
  logic                       pop_int;

  // ----------------------------------------
  // Downstream credits
  // ----------------------------------------
  generate
    for (genvar i = 0; i < `NUM_REQUESTORS; i++) begin : gen_credit
      credit_counter credit_counter_inst (
        .ap_clk        (ap_clk),
        .areset_control(areset_control),
        .grant         (credit_in[i]),
        .consume       (credit_consume[i]),
        .avail         (credit_avail[i])
      );
    end
  endgenerate

  // ----------------------------------------
  // Multicast pop rule
  // ----------------------------------------
  assign dest_mask = rd.head_packet.dest;

  // Every targeted requestor needs a credit, a zero mask is always ready
  assign targets_ready = ((dest_mask & ~credit_avail) == '0);

  assign pop_int = (state != SETUP) & rd.head_valid & targets_ready;
  assign rd.pop  = pop_int;

  // One credit taken from each named requestor
  assign credit_consume = pop_int ? dest_mask : '0;

  // ----------------------------------------
  // FSM
  // ----------------------------------------
  always_comb begin
    state_next = state;
    case (state)
      SETUP: begin
        if (!fifo_busy) begin
          state_next = IDLE;
        end
      end
      IDLE: begin
        if (pop_int) begin
          state_next = SEND;
        end
      end
      SEND: begin
        // Stay while back-to-back pops keep the outputs busy
        if (!pop_int) begin
          state_next = IDLE;
        end
      end
      default: begin
        state_next = SETUP;
      end
    endcase
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      state <= SETUP;
    end else begin
      state <= state_next;
    end
  end

  // ----------------------------------------
  // Registered outputs
  // ----------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      out_valid  <= '0;
      mem_credit <= 1'b0;
      setup_busy <= 1'b1;
    end else begin
      out_valid  <= pop_int ? dest_mask : '0;
      mem_credit <= pop_int;  // one upstream credit per freed entry
      setup_busy <= fifo_busy;
    end
  end

  // Payload held from the last pop
  always_ff @(posedge ap_clk) begin
    if (pop_int) begin
      out_opcode <= rd.head_packet.opcode;
      out_tag    <= rd.head_packet.tag;
      out_data   <= rd.head_packet.data;
    end
  end

endmodule : response_distributor

// File: design/response_fifo.sv
`timescale 1ns/100ps
`include "glay_macros.svh"

module response_fifo (
  input  logic                   ap_clk,
  input  logic                   areset_control,
  input  logic                   wr_en,
  input  memory_pkg::resp_packet_t wr_packet,
  fifo_read_if.source            rd,
  output logic                   busy
);
  import memory_pkg::*;

  // ----------------------------------------
  // Storage and pointers
  // ----------------------------------------
  resp_packet_t                  mem [`RESP_FIFO_DEPTH];
  logic [`FIFO_ADDR_WIDTH-1:0]   wr_ptr;
  logic [`FIFO_ADDR_WIDTH-1:0]   rd_ptr;
  logic [`FIFO_COUNT_WIDTH-1:0]  count;
  logic [`SETUP_COUNT_WIDTH-1:0] setup_cnt;

  logic full;
  logic wr_accept;
  logic rd_accept;

  assign full      = (count == `FIFO_COUNT_WIDTH'(`RESP_FIFO_DEPTH));
  assign wr_accept = wr_en & ~busy & ~full;
  assign rd_accept = rd.pop & rd.head_valid;

  // First word falls through to the head
  assign rd.head_valid  = (count != '0);
  assign rd.head_packet = mem[rd_ptr];

  // ----------------------------------------
  // Reset-busy period
  // ----------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      setup_cnt <= `SETUP_COUNT_WIDTH'(`SETUP_CYCLES);
    end else if (setup_cnt != '0) begin
      setup_cnt <= setup_cnt - 1'b1;
    end
  end

  assign busy = (setup_cnt != '0);

  // ----------------------------------------
  // Pointer and occupancy control
  // ----------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_accept) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_accept) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_accept, rd_accept})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Payload storage
  always_ff @(posedge ap_clk) begin
    if (wr_accept) begin
      mem[wr_ptr] <= wr_packet;
    end
  end

endmodule : response_fifo

// File: design/response_subsystem_top.sv
`timescale 1ns/100ps
`include "glay_macros.svh"

module response_subsystem_top (
  input  logic                       ap_clk,
  input  logic                       areset_control,
  input  logic                       resp_valid,
  input  memory_pkg::resp_opcode_e   resp_opcode,
  input  logic [`NUM_REQUESTORS-1:0] resp_dest,
  input  logic [`TAG_WIDTH-1:0]      resp_tag,
  input  logic [`DATA_WIDTH-1:0]     resp_data,
  input  logic [`NUM_REQUESTORS-1:0] credit_in,
  output logic [`NUM_REQUESTORS-1:0] out_valid,
  output memory_pkg::resp_opcode_e   out_opcode,
  output logic [`TAG_WIDTH-1:0]      out_tag,
  output logic [`DATA_WIDTH-1:0]     out_data,
  output logic                       mem_credit,
  output logic                       setup_busy
);
  import memory_pkg::*;

  logic         resp_valid_q;
  resp_packet_t resp_packet_q;
  logic         fifo_busy;

  fifo_read_if fifo_rd ();

  // ----------------------------------------
  // Input register stage
  // ----------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= resp_valid;
    end
  end

  // Fields packed into one FIFO word
  always_ff @(posedge ap_clk) begin
    resp_packet_q.opcode <= resp_opcode;
    resp_packet_q.dest   <= resp_dest;
    resp_packet_q.tag    <= resp_tag;
    resp_packet_q.data   <= resp_data;
  end

  // ----------------------------------------
  // FIFO and distributor
  // ----------------------------------------
  response_fifo response_fifo_inst (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .wr_en         (resp_valid_q),
    .wr_packet     (resp_packet_q),
    .rd            (fifo_rd.source),
    .busy          (fifo_busy)
  );

  response_distributor response_distributor_inst (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .rd            (fifo_rd.sink),
    .fifo_busy     (fifo_busy),
    .credit_in     (credit_in),
    .out_valid     (out_valid),
    .out_opcode    (out_opcode),
    .out_tag       (out_tag),
    .out_data      (out_data),
    .mem_credit    (mem_credit),
    .setup_busy    (setup_busy)
  );

endmodule : response_subsystem_top

// File: tb.f
+incdir+design
design/memory_pkg.sv
design/control_pkg.sv
design/fifo_read_if.sv
design/response_fifo.sv
design/credit_counter.sv
design/response_distributor.sv
design/response_subsystem_top.sv
verification/response_tb.sv

// File: verification/response_tb.sv
`timescale 1ns/100ps
`include "glay_macros.svh"

module response_tb;
  import memory_pkg::*;

  localparam int NUM_REQ      = `NUM_REQUESTORS;
  localparam int MAX_LINES    = 64;
  localparam int RESET_CYCLES = 8;
  localparam int DRAIN_CYCLES = 6;

  logic                   ap_clk;
  logic                   areset_control;
  logic                   resp_valid;
  resp_opcode_e           resp_opcode;
  logic [NUM_REQ-1:0]     resp_dest;
  logic [`TAG_WIDTH-1:0]  resp_tag;
  logic [`DATA_WIDTH-1:0] resp_data;
  logic [NUM_REQ-1:0]     credit_in;
  logic [NUM_REQ-1:0]     out_valid;
  resp_opcode_e           out_opcode;
  logic [`TAG_WIDTH-1:0]  out_tag;
  logic [`DATA_WIDTH-1:0] out_data;
  logic                   mem_credit;
  logic                   setup_busy;

  // One entry per response line of the test file
  resp_packet_t       vec [MAX_LINES];
  logic [NUM_REQ-1:0] vec_stall [MAX_LINES];

  // Expected response numbers per requestor in file order
  int exp_line [NUM_REQ][MAX_LINES];
  int exp_wr [NUM_REQ];
  int exp_rd [NUM_REQ];
  // Responses held by each requestor and not yet credited back
  int pending [NUM_REQ];

  int n_lines;
  int sent;
  int credits_seen;
  int mem_credits;
  int cycle;
  int gap;
  int limit;
  int drain;
  int errors;
  int tests_passed;
  int tests_failed;
  bit setup_done;
  bit timed_out;
  bit line_err;
  logic [NUM_REQ-1:0] stall;

  response_subsystem_top response_subsystem_top_inst (.*);

  initial begin
    ap_clk = 1'b0;
    forever #50 ap_clk = ~ap_clk;
  end

  // ----------------------------------------
  // Checking and reporting helpers
  // ----------------------------------------
  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[FAIL] t=%0t %s: got %0h expected %0h", $time, name, got, exp);
      errors++;
      line_err = 1'b1;
    end
  endtask

  task automatic check_true(input bit ok, input string what);
    assert (ok) else begin
      $display("ERROR at t=%0t: %s", $time, what);
      errors++;
      line_err = 1'b1;
    end
  endtask

  task automatic finish_test(input string name);
    if (line_err) begin
      tests_failed++;
    end else begin
      tests_passed++;
    end
    $display("%s : %s", name, line_err ? "FAILED" : "ok");
    line_err = 1'b0;
  endtask

  // Columns are opcode, dest mask, tag, data, stall mask
  task automatic load_tests();
    int fd;
    int rc;
    int i;
    string text;
    logic [31:0] f_op, f_dest, f_tag, f_data, f_stall;
    fd = $fopen("verification/response_tests.txt", "r");
    check_true(fd != 0, "could not open verification/response_tests.txt");
    while (fd != 0 && !$feof(fd) && n_lines < MAX_LINES) begin
      rc = $fgets(text, fd);
      if (rc > 0 && text.getc(0) != "#") begin
        rc = $sscanf(text, "%h %h %h %h %h", f_op, f_dest, f_tag, f_data, f_stall);
        if (rc == 5) begin
          vec[n_lines].opcode = resp_opcode_e'(f_op[1:0]);
          vec[n_lines].dest   = f_dest[NUM_REQ-1:0];
          vec[n_lines].tag    = f_tag[`TAG_WIDTH-1:0];
          vec[n_lines].data   = f_data;
          vec_stall[n_lines]  = f_stall[NUM_REQ-1:0];
          for (i = 0; i < NUM_REQ; i++) begin
            if (f_dest[i]) begin
              exp_line[i][exp_wr[i]] = n_lines;
              exp_wr[i]++;
            end
          end
          n_lines++;
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    check_true(n_lines > 0, "no responses were read from the test file");
  endtask

  // ----------------------------------------
  // Requestor and memory models
  // ----------------------------------------
  task automatic return_credits();
    int i;
    for (i = 0; i < NUM_REQ; i++) begin
      credit_in[i] = (pending[i] > 0) && !stall[i];
      if (credit_in[i]) begin
        pending[i]--;
      end
    end
  endtask

  task automatic drive_memory();
    resp_valid = 1'b0;
    if (setup_done && sent < n_lines && mem_credits > 0) begin
      if (gap > 0) begin
        gap--;
      end else begin
        resp_valid  = 1'b1;
        resp_opcode = vec[sent].opcode;
        resp_dest   = vec[sent].dest;
        resp_tag    = vec[sent].tag;
        resp_data   = vec[sent].data;
        stall       = vec_stall[sent];
        mem_credits--;
        sent++;
        gap = int'($urandom % 3);
      end
    end
    if (sent == n_lines) begin
      stall = '0;
    end
  endtask

  // In FIFO order the k-th mem_credit pulse frees response k
  task automatic check_outputs();
    int k;
    int i;
    check_true(mem_credit || out_valid == '0, "out_valid without a freed FIFO entry");
    if (mem_credit) begin
      k = credits_seen;
      credits_seen++;
      mem_credits++;
      check_true(mem_credits <= `RESP_FIFO_DEPTH, "more mem_credit pulses than responses sent");
      if (k < n_lines) begin
        check_value("out_valid", 32'(out_valid), 32'(vec[k].dest));
        if (vec[k].dest != '0) begin
          check_value("out_opcode", 32'(out_opcode), 32'(vec[k].opcode));
          check_value("out_tag", 32'(out_tag), 32'(vec[k].tag));
          check_value("out_data", out_data, vec[k].data);
        end
        for (i = 0; i < NUM_REQ; i++) begin
          if (out_valid[i]) begin
            pending[i]++;
            check_true(pending[i] <= `REQ_CREDITS,
                       $sformatf("requestor %0d got more responses than its credits", i));
            check_true(exp_rd[i] < exp_wr[i] && exp_line[i][exp_rd[i]] == k,
                       $sformatf("requestor %0d got response %0d out of order", i, k + 1));
            if (exp_rd[i] < exp_wr[i]) begin
              exp_rd[i]++;
            end
          end
        end
        finish_test($sformatf("response %0d tag %h dest %b", k + 1, vec[k].tag, vec[k].dest));
      end else begin
        check_true(1'b0, "mem_credit pulse with no response left to free");
      end
    end
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    int i;
    void'($urandom(32'h7dda_59ff));
    areset_control = 1'b1;
    resp_valid     = 1'b0;
    resp_opcode    = RESP_READ_DATA;
    resp_dest      = '0;
    resp_tag       = '0;
    resp_data      = '0;
    credit_in      = '0;
    stall          = '0;
    load_tests();
    limit       = 20 * n_lines + `SETUP_CYCLES + RESET_CYCLES;
    mem_credits = `RESP_FIFO_DEPTH;
    drain       = DRAIN_CYCLES;
    repeat (RESET_CYCLES) @(negedge ap_clk);
    areset_control = 1'b0;

    while (!timed_out && drain > 0) begin
      @(negedge ap_clk);
      cycle++;
      if (!setup_done) begin
        if (cycle == 1) begin
          check_true(setup_busy === 1'b1, "setup_busy was low right after reset");
        end
        if (setup_busy === 1'b0) begin
          setup_done = 1'b1;
          check_true(cycle <= `SETUP_CYCLES + 3, "setup_busy stayed high too long");
          finish_test("setup phase");
        end
      end
      if (sent == 0) begin
        check_true(out_valid == '0 && mem_credit == 1'b0, "output activity before any send");
      end
      return_credits();
      check_outputs();
      drive_memory();
      if (credits_seen >= n_lines) begin
        drain--;
      end
      if (cycle >= limit) begin
        timed_out = 1'b1;
      end
    end

    if (timed_out) begin
      $display("Timeout: %0d cycles passed with %0d of %0d responses freed",
               cycle, credits_seen, n_lines);
    end else begin
      check_true(credits_seen == sent && sent == n_lines, "mem_credit count differs from sends");
      check_true(mem_credits == `RESP_FIFO_DEPTH, "memory side did not get all credits back");
      for (i = 0; i < NUM_REQ; i++) begin
        check_true(exp_rd[i] == exp_wr[i], $sformatf("requestor %0d lost responses", i));
      end
      finish_test("upstream credit totals");
    end
    $display("%0d tests passed, %0d tests failed, %0d check errors",
             tests_passed, tests_failed, errors);
    if (timed_out || errors != 0 || tests_failed != 0) begin
      $display("Test failures found");
    end else begin
      $display("All tests passed!");
    end
    $finish;
  end

endmodule : response_tb

// File: verification/response_tests.txt
# opcode dest tag data stall, all hex; opcode 0 read data, 1 write ack
# dest and stall hold one bit per requestor, requestor 0 in bit 0
0 1 01 10000001 0
0 2 02 20000002 0
1 4 03 30000003 0
0 8 04 40000004 0
1 1 05 50000005 0
0 3 06 60000006 0
1 f 07 70000007 0
0 0 08 80000008 0
0 c 09 90000009 0
0 0 0a a000000a 0
0 2 0b b000000b 2
0 2 0c c000000c 2
1 2 0d d000000d 2
0 1 0e e000000e 2
0 6 0f f000000f 2
1 8 10 01010101 2
0 2 11 02020202 0
0 5 12 03030303 0
0 8 13 04040404 8
1 9 14 05050505 8
0 8 15 06060606 8
0 0 16 07070707 8
0 4 17 08080808 0
1 f 18 09090909 0
0 a 19 0a0a0a0a 0
1 1 1a 0b0b0b0b 0
